// ==== common/coreTypes.sv ====
`default_nettype none

package coreTypes;

    // **************************************************
    // ISA widths
    // **************************************************
    // Datapath width, fixed by RV32I
    localparam int XLEN       = 32;
    // x0..x31
    localparam int REG_ADDR_W = 5;

    // **************************************************
    // Encodings
    // **************************************************
    // Major opcodes of the supported subset, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcodeT;

    // ALU operations
    // PASS_B hands operand B straight through, used by LUI
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B
    } aluOpT;

    // Branch kind, resolved in execute
    typedef enum logic [1:0] {
        NONE,
        BEQ,
        BNE,
        JUMP
    } branchT;

    // Operand source select from the hazard unit
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX,
        FWD_MEM
    } forwardSelT;

endpackage

`default_nettype wire

// ==== common/pipeIfs.sv ====
`default_nettype none

// **************************************************
// Decode to execute, the ID/EX register contents
// **************************************************
interface decExIf import coreTypes::*; ();
    logic                  valid;
    logic [XLEN-1:0]       pc;
    // Branch or jump target, pc + imm
    logic [XLEN-1:0]       target;
    logic [XLEN-1:0]       rs1Data;
    logic [XLEN-1:0]       rs2Data;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1Addr;
    logic [REG_ADDR_W-1:0] rs2Addr;
    logic [REG_ADDR_W-1:0] rdAddr;
    aluOpT                 aluOp;
    logic                  useImm;
    logic                  usePcPlus4;
    branchT                branch;
    logic                  memRead;
    logic                  memWrite;
    logic                  regWrite;

    modport source (output valid, pc, target, rs1Data, rs2Data, imm, rs1Addr, rs2Addr,
                    rdAddr, aluOp, useImm, usePcPlus4, branch, memRead, memWrite, regWrite);
    modport sink   (input  valid, pc, target, rs1Data, rs2Data, imm, rs1Addr, rs2Addr,
                    rdAddr, aluOp, useImm, usePcPlus4, branch, memRead, memWrite, regWrite);
endinterface

// **************************************************
// Execute to memory, the EX/MEM register contents
// **************************************************
interface exMemIf import coreTypes::*; ();
    logic                  valid;
    // Also the EX-result forwarding value
    logic [XLEN-1:0]       aluResult;
    logic [XLEN-1:0]       storeData;
    logic [REG_ADDR_W-1:0] rdAddr;
    logic                  memRead;
    logic                  memWrite;
    logic                  regWrite;

    modport source (output valid, aluResult, storeData, rdAddr, memRead, memWrite, regWrite);
    modport sink   (input  valid, aluResult, storeData, rdAddr, memRead, memWrite, regWrite);
endinterface

`default_nettype wire

// ==== decode/registerFile.sv ====
`default_nettype none

module registerFile import coreTypes::*; (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic [REG_ADDR_W-1:0] rdAddrA,
    input  logic [REG_ADDR_W-1:0] rdAddrB,
    input  logic                  wrEn,
    input  logic [REG_ADDR_W-1:0] wrAddr,
    input  logic [XLEN-1:0]       wrData,
    output logic [XLEN-1:0]       rdDataA,
    output logic [XLEN-1:0]       rdDataB
);

    logic [XLEN-1:0] regs [32];

    // Architectural state starts at zero, x0 never written
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-through covers write-back vs. decode in the same cycle
    assign rdDataA = (rdAddrA == '0) ? '0 :
                     (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 :
                     (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== decode/decodeStage.sv ====
`default_nettype none

module decodeStage import coreTypes::*; (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic [31:0]           instr,
    input  logic [31:0]           instrPc,
    input  logic                  instrFire,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  wbValid,
    input  logic [REG_ADDR_W-1:0] wbRd,
    input  logic [XLEN-1:0]       wbData,
    decExIf.source                dx
);

    opcodeT                opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]       rs1Data, rs2Data;
    logic                  take;
    logic                  knownOp;

    // Decoded controls, registered into ID/EX
    aluOpT           aluOpNext;
    logic [XLEN-1:0] immNext;
    logic            useImmNext, usePcPlus4Next;
    branchT          branchNext;
    logic            memReadNext, memWriteNext, regWriteNext;

    // funct3 plus the instr[30] alternate bit to an ALU op
    function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    // Instruction fields
    assign opcode = opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign knownOp = opcode inside {OP, OP_IMM, LUI, LOAD, STORE, BRANCH, JAL};

    registerFile regFile (
        .Clk     (Clk),
        .rstN    (rstN),
        .rdAddrA (rs1),
        .rdAddrB (rs2),
        .wrEn    (wbValid),
        .wrAddr  (wbRd),
        .wrData  (wbData),
        .rdDataA (rs1Data),
        .rdDataB (rs2Data)
    );

    // **************************************************
    // Control decode
    // **************************************************
    always_comb begin
        aluOpNext      = ADD;
        immNext        = '0;
        useImmNext     = 1'b0;
        usePcPlus4Next = 1'b0;
        branchNext     = NONE;
        memReadNext    = 1'b0;
        memWriteNext   = 1'b0;
        regWriteNext   = 1'b0;
        case (opcode)
            OP: begin
                aluOpNext    = aluFromFunct(funct3, instr[30]);
                regWriteNext = 1'b1;
            end
            OP_IMM: begin
                // Only shifts honour instr[30] in I-type
                aluOpNext    = aluFromFunct(funct3, instr[30] && funct3 == 3'b101);
                immNext      = {{20{instr[31]}}, instr[31:20]};
                useImmNext   = 1'b1;
                regWriteNext = 1'b1;
            end
            LUI: begin
                aluOpNext    = PASS_B;
                immNext      = {instr[31:12], 12'b0};
                useImmNext   = 1'b1;
                regWriteNext = 1'b1;
            end
            LOAD: begin
                immNext      = {{20{instr[31]}}, instr[31:20]};
                useImmNext   = 1'b1;
                memReadNext  = 1'b1;
                regWriteNext = 1'b1;
            end
            STORE: begin
                immNext      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                useImmNext   = 1'b1;
                memWriteNext = 1'b1;
            end
            BRANCH: begin
                immNext    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
                // Other conditions unsupported, treated as no branch
                branchNext = (funct3 == 3'b000) ? BEQ :
                             (funct3 == 3'b001) ? BNE : NONE;
            end
            JAL: begin
                // Link value pc + 4 through the ALU
                immNext        = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
                usePcPlus4Next = 1'b1;
                branchNext     = JUMP;
                regWriteNext   = 1'b1;
            end
            default: ;
        endcase
    end

    // Bubble on stall, flush or no fired instruction
    assign take = instrFire && !stall && !flush;

    // **************************************************
    // ID/EX register
    // **************************************************
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            dx.valid    <= 1'b0;
            dx.branch   <= NONE;
            dx.memRead  <= 1'b0;
            dx.memWrite <= 1'b0;
            dx.regWrite <= 1'b0;
        end else begin
            dx.valid    <= take;
            dx.branch   <= take ? branchNext : NONE;
            dx.memRead  <= take && memReadNext;
            dx.memWrite <= take && memWriteNext;
            // x0 destinations never reach write-back
            dx.regWrite <= take && regWriteNext && rd != '0;
        end
    end

    // Payload, held while no instruction enters
    always_ff @(posedge Clk) begin
        if (take) begin
            dx.pc         <= instrPc;
            dx.target     <= instrPc + immNext;
            dx.rs1Data    <= rs1Data;
            dx.rs2Data    <= rs2Data;
            dx.imm        <= immNext;
            dx.rs1Addr    <= rs1;
            dx.rs2Addr    <= rs2;
            dx.rdAddr     <= rd;
            dx.aluOp      <= aluOpNext;
            dx.useImm     <= useImmNext;
            dx.usePcPlus4 <= usePcPlus4Next;
        end
    end

    // Feeder only issues subset opcodes
    assert property (@(posedge Clk) disable iff (!rstN) instrFire && !flush |-> knownOp)
        else $error("decode accepted unknown opcode %b", instr[6:0]);

    // Stall bubble empties ID/EX and so ends the load-use stall
    assert property (@(posedge Clk) disable iff (!rstN) stall |=> !stall)
        else $error("load-use stall lasted more than one cycle");

endmodule

`default_nettype wire

// ==== execute/executeAlu.sv ====
`default_nettype none

module executeAlu import coreTypes::*; (
    input  aluOpT           aluOp,
    input  logic [XLEN-1:0] opA,
    input  logic [XLEN-1:0] opB,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;

    // Shift amount from the low bits of B only
    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            ADD:    result = opA + opB;
            SUB:    result = opA - opB;
            AND:    result = opA & opB;
            OR:     result = opA | opB;
            XOR:    result = opA ^ opB;
            // Signed compare
            SLT:    result = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            // Unsigned compare
            SLTU:   result = {{(XLEN-1){1'b0}}, opA < opB};
            SLL:    result = opA << shamt;
            SRL:    result = opA >> shamt;
            // Arithmetic, sign bit fills
            SRA:    result = $unsigned($signed(opA) >>> shamt);
            // LUI immediate
            PASS_B: result = opB;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== execute/executeStage.sv ====
`default_nettype none

module executeStage import coreTypes::*; (
    input  logic            Clk,
    input  logic            rstN,
    decExIf.sink            dx,
    input  forwardSelT      fwdA,
    input  forwardSelT      fwdB,
    input  logic [XLEN-1:0] wbData,
    exMemIf.source          xm,
    output logic            redirect,
    output logic [XLEN-1:0] redirectPc
);

    logic [XLEN-1:0] rs1Val, rs2Val;
    logic [XLEN-1:0] opA, opB;
    logic [XLEN-1:0] aluResult;
    logic            usePc;
    logic            live;
    logic            equal;
    logic            taken;

    // Forwarded value wins over register data
    function automatic logic [XLEN-1:0] fwdMux(input forwardSelT sel,
                                               input logic [XLEN-1:0] regVal,
                                               input logic [XLEN-1:0] exVal,
                                               input logic [XLEN-1:0] memVal);
        logic [XLEN-1:0] val;
        case (sel)
            FWD_EX:  val = exVal;
            FWD_MEM: val = memVal;
            default: val = regVal;
        endcase
        return val;
    endfunction

    // **************************************************
    // Operand selection
    // **************************************************
    assign rs1Val = fwdMux(fwdA, dx.rs1Data, xm.aluResult, wbData);
    assign rs2Val = fwdMux(fwdB, dx.rs2Data, xm.aluResult, wbData);

    // pc as operand A for JAL and LUI
    assign usePc = dx.usePcPlus4 || dx.aluOp == PASS_B;
    assign opA   = usePc ? dx.pc : rs1Val;
    // JAL link value, pc + 4
    assign opB   = dx.usePcPlus4 ? XLEN'(4) :
                   dx.useImm     ? dx.imm : rs2Val;

    executeAlu alu (
        .aluOp  (dx.aluOp),
        .opA    (opA),
        .opB    (opB),
        .result (aluResult)
    );

    // **************************************************
    // Branch resolution
    // **************************************************
    // Compare on forwarded register values
    assign equal = rs1Val == rs2Val;
    always_comb begin
        case (dx.branch)
            BEQ:     taken = equal;
            BNE:     taken = !equal;
            JUMP:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Instruction in ID/EX is a shadow while redirect is up
    assign live = dx.valid && !redirect;

    // **************************************************
    // EX/MEM register
    // **************************************************
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            xm.valid    <= 1'b0;
            xm.memRead  <= 1'b0;
            xm.memWrite <= 1'b0;
            xm.regWrite <= 1'b0;
            redirect    <= 1'b0;
        end else begin
            xm.valid    <= live;
            xm.memRead  <= live && dx.memRead;
            xm.memWrite <= live && dx.memWrite;
            xm.regWrite <= live && dx.regWrite;
            redirect    <= live && taken;
        end
    end

    // Results and target, qualified by the control bits above
    always_ff @(posedge Clk) begin
        xm.aluResult <= aluResult;
        xm.storeData <= rs2Val;
        xm.rdAddr    <= dx.rdAddr;
        redirectPc   <= dx.target;
    end

    // Shadow squash keeps redirects apart
    assert property (@(posedge Clk) disable iff (!rstN) redirect |=> !redirect)
        else $error("redirect high two cycles in a row");

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`default_nettype none

module hazardUnit import coreTypes::*; (
    decExIf.sink                  dx,
    exMemIf.sink                  xm,
    input  logic                  wbValid,
    input  logic [REG_ADDR_W-1:0] wbRd,
    input  logic [REG_ADDR_W-1:0] instrRs1,
    input  logic [REG_ADDR_W-1:0] instrRs2,
    input  logic                  instrFire,
    output forwardSelT            fwdA,
    output forwardSelT            fwdB,
    output logic                  stall
);

    // EX/MEM beats write-back, it is the younger producer
    function automatic forwardSelT pickFwd(input logic [REG_ADDR_W-1:0] src);
        forwardSelT sel;
        if (xm.regWrite && xm.rdAddr != '0 && xm.rdAddr == src) begin
            sel = FWD_EX;
        end else if (wbValid && wbRd != '0 && wbRd == src) begin
            sel = FWD_MEM;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    assign fwdA = pickFwd(dx.rs1Addr);
    assign fwdB = pickFwd(dx.rs2Addr);

    // Load in ID/EX feeding the incoming instruction
    // Load data only exists after MEM, one bubble needed
    assign stall = instrFire && dx.valid && dx.memRead && dx.rdAddr != '0 &&
                   (dx.rdAddr == instrRs1 || dx.rdAddr == instrRs2);

endmodule

`default_nettype wire

// ==== source/memoryStage.sv ====
`default_nettype none

module memoryStage import coreTypes::*; #(
    parameter int memDepth = 256
) (
    input  logic                  Clk,
    input  logic                  rstN,
    exMemIf.sink                  xm,
    output logic                  wbValid,
    output logic [REG_ADDR_W-1:0] wbRd,
    output logic [XLEN-1:0]       wbData
);

    localparam int IDX_W = $clog2(memDepth);

    logic [XLEN-1:0]  dataMem [memDepth];
    logic [IDX_W-1:0] wordIdx;
    logic [XLEN-1:0]  loadData;

    // Word addressed, byte offset ignored
    assign wordIdx  = xm.aluResult[IDX_W+1:2];
    assign loadData = dataMem[wordIdx];

    // **************************************************
    // Data memory
    // **************************************************
    always_ff @(posedge Clk) begin
        if (xm.valid && xm.memWrite) begin
            dataMem[wordIdx] <= xm.storeData;
        end
    end

    // **************************************************
    // MEM/WB register
    // **************************************************
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            // Only rd writers show up on write-back
            wbValid <= xm.valid && xm.regWrite;
        end
    end

    always_ff @(posedge Clk) begin
        wbRd   <= xm.rdAddr;
        // Load data or ALU result
        wbData <= xm.memRead ? loadData : xm.aluResult;
    end

    // Decode sets at most one memory control
    assert property (@(posedge Clk) disable iff (!rstN) !(xm.memRead && xm.memWrite))
        else $error("memRead and memWrite both set");

endmodule

`default_nettype wire

// ==== source/coreTop.sv ====
`default_nettype none

module coreTop import coreTypes::*; #(
    parameter int memDepth = 256
) (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  instrValid,
    input  logic [31:0]           instr,
    input  logic [31:0]           instrPc,
    output logic                  instrReady,
    output logic                  redirect,
    output logic [XLEN-1:0]       redirectPc,
    output logic                  wbValid,
    output logic [REG_ADDR_W-1:0] wbRd,
    output logic [XLEN-1:0]       wbData
);

    decExIf dx ();
    exMemIf xm ();

    forwardSelT fwdA, fwdB;
    logic       stall;
    logic       instrFire;
    logic       outOfReset;

    // Ready rises on the first edge after reset
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            outOfReset <= 1'b0;
        end else begin
            outOfReset <= 1'b1;
        end
    end

    assign instrReady = outOfReset && !stall;
    assign instrFire  = instrValid && instrReady;

    // **************************************************
    // Pipeline stages
    // **************************************************
    decodeStage decode (
        .Clk       (Clk),
        .rstN      (rstN),
        .instr     (instr),
        .instrPc   (instrPc),
        .instrFire (instrFire),
        .stall     (stall),
        .flush     (redirect),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbData    (wbData),
        .dx        (dx.source)
    );

    executeStage execute (
        .Clk        (Clk),
        .rstN       (rstN),
        .dx         (dx.sink),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .wbData     (wbData),
        .xm         (xm.source),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    // Stall qualified by the presented instruction
    // The fired one depends on ready, which depends on stall
    hazardUnit hazard (
        .dx        (dx.sink),
        .xm        (xm.sink),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .instrRs1  (instr[19:15]),
        .instrRs2  (instr[24:20]),
        .instrFire (instrValid),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .stall     (stall)
    );

    memoryStage #(
        .memDepth (memDepth)
    ) memory (
        .Clk     (Clk),
        .rstN    (rstN),
        .xm      (xm.sink),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

endmodule

`default_nettype wire

// ==== tb/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH
// Columns: prog[word index] = encoded instruction, word index is pc/4
// ALU register forms, dependencies at distance 1 and 2
prog[0]  = encI(OP_IMM, 12'd5, 5'd0, 3'b000, 5'd1);
prog[1]  = encI(OP_IMM, -12'sd3, 5'd0, 3'b000, 5'd2);
prog[2]  = encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
prog[3]  = encR(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
prog[4]  = encR(7'h00, 5'd2, 5'd4, 3'b111, 5'd5);
prog[5]  = encR(7'h00, 5'd1, 5'd4, 3'b110, 5'd6);
prog[6]  = encR(7'h00, 5'd2, 5'd6, 3'b100, 5'd7);
prog[7]  = encR(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);
prog[8]  = encR(7'h00, 5'd1, 5'd2, 3'b011, 5'd9);
prog[9]  = encR(7'h00, 5'd1, 5'd1, 3'b001, 5'd10);
prog[10] = encR(7'h00, 5'd1, 5'd2, 3'b101, 5'd11);
prog[11] = encR(7'h20, 5'd1, 5'd2, 3'b101, 5'd12);
// LUI and immediate forms
prog[12] = encU(20'hABCDE, 5'd13);
prog[13] = encI(OP_IMM, 12'd1, 5'd2, 3'b010, 5'd14);
prog[14] = encI(OP_IMM, 12'd1, 5'd2, 3'b011, 5'd15);
prog[15] = encI(OP_IMM, 12'h0ff, 5'd1, 3'b100, 5'd16);
prog[16] = encI(OP_IMM, 12'h070, 5'd2, 3'b110, 5'd17);
prog[17] = encI(OP_IMM, 12'h07f, 5'd2, 3'b111, 5'd18);
prog[18] = encI(OP_IMM, 12'h004, 5'd2, 3'b001, 5'd19);
prog[19] = encI(OP_IMM, 12'h004, 5'd2, 3'b101, 5'd20);
prog[20] = encI(OP_IMM, 12'h404, 5'd2, 3'b101, 5'd21);
// Store, load, then an immediate consumer
prog[21] = encS(12'd8, 5'd13, 5'd0);
prog[22] = encI(LOAD, 12'd8, 5'd0, 3'b010, 5'd22);
prog[23] = encR(7'h00, 5'd1, 5'd22, 3'b000, 5'd23);
// x0 write, then read back through an add
prog[24] = encI(OP_IMM, 12'd77, 5'd0, 3'b000, 5'd0);
prog[25] = encR(7'h00, 5'd1, 5'd0, 3'b000, 5'd24);
// Taken BEQ and BNE, each with two sentinel shadows
prog[26] = encB(13'd12, 5'd1, 5'd1, 3'b000);
prog[27] = encI(OP_IMM, 12'd111, 5'd0, 3'b000, 5'd25);
prog[28] = encI(OP_IMM, 12'd222, 5'd0, 3'b000, 5'd25);
prog[29] = encB(13'd12, 5'd2, 5'd1, 3'b001);
prog[30] = encI(OP_IMM, 12'd333, 5'd0, 3'b000, 5'd26);
prog[31] = encI(OP_IMM, 12'd444, 5'd0, 3'b000, 5'd26);
// Not taken
prog[32] = encB(13'd8, 5'd2, 5'd1, 3'b000);
prog[33] = encB(13'd8, 5'd1, 5'd1, 3'b001);
// JAL over two sentinels, link value forwarded
prog[34] = encJ(21'd12, 5'd27);
prog[35] = encI(OP_IMM, 12'd555, 5'd0, 3'b000, 5'd28);
prog[36] = encI(OP_IMM, 12'd666, 5'd0, 3'b000, 5'd28);
prog[37] = encR(7'h00, 5'd1, 5'd27, 3'b000, 5'd28);
prog[38] = encI(OP_IMM, 12'd1, 5'd28, 3'b000, 5'd29);
prog[39] = encR(7'h00, 5'd0, 5'd29, 3'b000, 5'd30);
`endif

// ==== tb/coreTb.sv ====
`default_nettype none

module coreTb import coreTypes::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN  = 40;
    // Idle cycles only from the branch section on
    localparam int IDLE_FROM = 26;
    localparam int LIMIT     = 4 * PROG_LEN + 50;

    logic        Clk = 1'b0;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] instrPc;
    logic        instrReady;
    logic        redirect;
    logic [31:0] redirectPc;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] pc;
    logic [31:0] lcgState;
    // Expected write-back pairs and redirect targets
    logic [4:0]  expRd [64];
    logic [31:0] expVal [64];
    logic [31:0] expTgt [16];
    int          expWbCnt;
    int          expRedCnt;
    int          wbIdx;
    int          redIdx;
    int          cycles;
    int          stallCycles;

    coreTop #(.memDepth(256)) uut (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc),
        .instrReady (instrReady),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

    always #4 Clk = !Clk;

    // **************************************************
    // Encoders
    // **************************************************
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] encI(input opcodeT op, input logic [11:0] imm,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, LUI};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    task automatic buildProgram();
        `include "tbProgram.svh"
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // **************************************************
    // ISA reference model
    // **************************************************
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic runModel();
        logic [31:0] r [32];
        logic [31:0] mem [256];
        logic [31:0] w, p, immI, immS, immB, immJ, res;
        logic        wr;
        int          steps;
        p = 0;
        steps = 0;
        for (int i = 0; i < 32; i++) r[i] = 0;
        while (p / 4 < PROG_LEN && steps < 1000) begin
            w    = prog[p / 4];
            immI = {{20{w[31]}}, w[31:20]};
            immS = {{20{w[31]}}, w[31:25], w[11:7]};
            immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            wr   = 1'b1;
            res  = 0;
            case (opcodeT'(w[6:0]))
                OP:     res = refAlu(w[14:12], w[30], r[w[19:15]], r[w[24:20]]);
                OP_IMM: res = refAlu(w[14:12], w[30] && w[14:12] == 3'b101,
                                     r[w[19:15]], immI);
                LUI:    res = {w[31:12], 12'b0};
                LOAD:   res = mem[((r[w[19:15]] + immI) >> 2) & 255];
                STORE: begin
                    mem[((r[w[19:15]] + immS) >> 2) & 255] = r[w[24:20]];
                    wr = 1'b0;
                end
                BRANCH: wr = 1'b0;
                JAL:    res = p + 4;
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 0) begin
                r[w[11:7]]        = res;
                expRd[expWbCnt]   = w[11:7];
                expVal[expWbCnt]  = res;
                expWbCnt++;
            end
            // Taken branch or jump leaves a redirect target
            if ((w[6:0] == BRANCH && ((w[14:12] == 3'b000) ==
                 (r[w[19:15]] == r[w[24:20]]))) || w[6:0] == JAL) begin
                p = p + ((w[6:0] == JAL) ? immJ : immB);
                expTgt[expRedCnt] = p;
                expRedCnt++;
            end else begin
                p = p + 4;
            end
            steps++;
        end
    endtask

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // **************************************************
    // Instruction feeder
    // **************************************************
    always @(posedge Clk) begin : feed
        logic [31:0] nextPc;
        int          idx;
        if (rstN) begin
            nextPc = pc;
            // Presented instruction is dropped while redirect is up
            if (redirect) begin
                nextPc = redirectPc;
            end else if (instrValid && instrReady) begin
                nextPc = pc + 4;
            end
            idx      = nextPc / 4;
            lcgState = lcgNext(lcgState);
            pc         <= nextPc;
            instrPc    <= nextPc;
            instr      <= (idx < PROG_LEN) ? prog[idx] : 32'h0000_0013;
            instrValid <= idx < PROG_LEN && !(idx >= IDLE_FROM && lcgState[16]);
        end
    end

    // Scoreboard pointers, stall count and watchdog
    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (wbValid) wbIdx <= wbIdx + 1;
        if (redirect) redIdx <= redIdx + 1;
        if (rstN && instrValid && !instrReady) stallCycles <= stallCycles + 1;
        if (cycles > LIMIT) begin
            failRun($sformatf("Run hung, no completion after %0d cycles", LIMIT));
        end
    end

    // **************************************************
    // Checks
    // **************************************************
    assert property (@(posedge Clk) disable iff (!rstN) wbValid |-> wbIdx < expWbCnt)
        else failRun($sformatf("Unexpected extra write-back to x%0d", $sampled(wbRd)));
    assert property (@(posedge Clk) disable iff (!rstN)
                     wbValid && wbIdx < expWbCnt |-> wbRd == expRd[wbIdx])
        else failRun($sformatf("[ERROR] %0t wbRd expected %0d actual %0d", $time,
                     expRd[$sampled(wbIdx)], $sampled(wbRd)));
    assert property (@(posedge Clk) disable iff (!rstN)
                     wbValid && wbIdx < expWbCnt |-> wbData == expVal[wbIdx])
        else failRun($sformatf("[ERROR] %0t wbData expected %h actual %h", $time,
                     expVal[$sampled(wbIdx)], $sampled(wbData)));
    assert property (@(posedge Clk) disable iff (!rstN) redirect |-> redIdx < expRedCnt)
        else failRun("A redirect happened where no branch was taken");
    assert property (@(posedge Clk) disable iff (!rstN)
                     redirect && redIdx < expRedCnt |-> redirectPc == expTgt[redIdx])
        else failRun($sformatf("[ERROR] %0t redirectPc expected %h actual %h", $time,
                     expTgt[$sampled(redIdx)], $sampled(redirectPc)));

    initial begin
        expWbCnt    = 0;
        expRedCnt   = 0;
        wbIdx       = 0;
        redIdx      = 0;
        cycles      = 0;
        stallCycles = 0;
        lcgState    = 32'h7ae60770;
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instr       = 32'h0000_0013;
        instrPc     = '0;
        pc          = '0;
        buildProgram();
        runModel();
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
        // Done once the program is consumed and all results seen
        while (!(pc / 4 >= PROG_LEN && wbIdx == expWbCnt && redIdx == expRedCnt)) begin
            @(posedge Clk);
        end
        repeat (4) @(posedge Clk);
        // One load-use pair in the program, so exactly one stall cycle
        if (wbIdx == expWbCnt && redIdx == expRedCnt && stallCycles == 1) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Missing results or load-use stall not exactly one cycle");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tb
common/coreTypes.sv
common/pipeIfs.sv
decode/registerFile.sv
decode/decodeStage.sv
execute/executeAlu.sv
execute/executeStage.sv
source/hazardUnit.sv
source/memoryStage.sv
source/coreTop.sv
tb/coreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= coreTb
FILELIST  ?= sources.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
